//--- rtl/serial_cmd_defines.svh
`ifndef SERIAL_CMD_DEFINES_SVH
`define SERIAL_CMD_DEFINES_SVH

// **********************************************************
// Serial line timing
// **********************************************************

// Width of the half-bit period input, in xclk cycles.
`define SER_HALF_W 16

// **********************************************************
// Byte buffer
// **********************************************************

// The depth must stay a power of two so the pointers wrap on their own.
`define SER_FIFO_DEPTH 4
`define SER_FIFO_AW 2

// **********************************************************
// Command packets
// **********************************************************

// Address byte, then data low byte, then data high byte.
`define SER_PKT_BYTES 3

`endif

//--- rtl/serial_line_pkg.sv
`include "serial_cmd_defines.svh"

package serial_line_pkg;

  // **********************************************************
  // Line timing
  // **********************************************************

  // Number of xclk cycles in half a bit on the line.
  typedef logic [`SER_HALF_W-1:0] half_period_t;

  // Half-bit counter of one frame. Values 19..0 cover a whole frame of
  // start, eight data bits and stop; 18 is loaded at the start strobe,
  // so the last count falls in the middle of the stop bit.
  typedef logic [4:0] bit_cnt_t;

  // **********************************************************
  // Receiver control
  // **********************************************************

  // wait_pause  line must stay idle for one frame, starts are ignored.
  // wait_start  armed for the next falling edge.
  // receiving   inside a frame.
  typedef enum logic [1:0] {
    wait_pause,
    wait_start,
    receiving
  } rx_state_t;

endpackage

//--- rtl/serial_data_pkg.sv
`include "serial_cmd_defines.svh"

package serial_data_pkg;

  // **********************************************************
  // Received bytes and the byte buffer
  // **********************************************************

  typedef logic [7:0] byte_t;
  typedef logic [2:0] bit_pos_t;   // Bit position inside the byte being assembled.

  typedef logic [`SER_FIFO_AW-1:0] fifo_ptr_t;
  typedef logic [`SER_FIFO_AW:0]   fifo_cnt_t;  // One bit wider to hold a full count.

  // **********************************************************
  // Register commands
  // **********************************************************

  typedef logic [7:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;
  typedef logic [7:0]  drop_cnt_t;   // Saturates at 255.

  // Index of the next byte within a packet.
  typedef logic [1:0] pkt_idx_t;

  typedef enum logic [1:0] {
    idle,
    pop,
    take
  } parse_state_t;

endpackage

//--- rtl/rs232_rcv.sv
`timescale 1ns/1ps

module rs232_rcv (
  input  logic                          xclk,
  input  logic                          reset_bit_duration,
  input  serial_line_pkg::half_period_t bit_half_period,
  input  logic                          ser_di,
  output logic                          ser_do,
  output logic                          ser_do_stb,
  output logic                          ts_stb,
  output logic                          frame_err
);
  import serial_line_pkg::*;

  logic [4:0]   ser_di_d;         // Raw line history for the filter.
  logic         ser_filt_di;
  logic         ser_filt_di_d;
  half_period_t bit_dur_cntr;
  logic         bit_half_end;
  bit_cnt_t     bit_cntr;
  rx_state_t    state;
  logic         pause_seen;       // A full idle frame went by since the last start.
  logic         start;
  logic         bit_hold;

  logic         wstart;
  logic         frame_end;
  logic         pause_rst;
  logic         reload_dur;
  logic         sample_bit;
  logic         shift_bit;

  // **********************************************************
  // Line filter
  // **********************************************************

  // The filtered line only moves after five equal samples.
  always_ff @(posedge xclk) begin
    ser_di_d <= {ser_di_d[3:0], ser_di};
    if (reset_bit_duration || &ser_di_d) begin
      ser_filt_di <= 1'b1;
    end else if (~|ser_di_d) begin
      ser_filt_di <= 1'b0;
    end
    if (reset_bit_duration) ser_filt_di_d <= 1'b1;
    else                    ser_filt_di_d <= ser_filt_di;
  end

  // **********************************************************
  // Half-bit timing
  // **********************************************************

  assign wstart    = (state == wait_start) && ser_filt_di_d && !ser_filt_di;
  assign frame_end = bit_half_end && (bit_cntr == '0);

  // Any low level restarts the idle count before the first pause.
  assign pause_rst  = ((state == wait_pause) && !ser_filt_di) ||
                      ((state == receiving) && frame_end);
  assign reload_dur = reset_bit_duration || start || bit_half_end || pause_rst;

  // Counts 2..16 (even) are the middles of data bits 7..0.
  assign sample_bit = (state == receiving) && bit_half_end && !bit_cntr[0] &&
                      (bit_cntr >= bit_cnt_t'(2)) && (bit_cntr <= bit_cnt_t'(16));

  // Each bit goes out at the next sample point, so that the last data bit
  // leaves together with the stop-bit check.
  assign shift_bit = (state == receiving) && bit_half_end && !bit_cntr[0] &&
                     (bit_cntr <= bit_cnt_t'(14));

  always_ff @(posedge xclk) begin
    if (reload_dur) bit_dur_cntr <= bit_half_period - 1'b1;  // Minimum period is 2.
    else            bit_dur_cntr <= bit_dur_cntr - 1'b1;
    bit_half_end <= (bit_dur_cntr == half_period_t'(1)) && !reload_dur;

    if (reset_bit_duration || pause_rst) begin
      bit_cntr <= bit_cnt_t'(19);
    end else if (start) begin
      bit_cntr <= bit_cnt_t'(18);
    end else if (bit_half_end && (bit_cntr != '0)) begin
      bit_cntr <= bit_cntr - 1'b1;                           // Holds at zero when idle.
    end
  end

  // **********************************************************
  // Frame control
  // **********************************************************

  always_ff @(posedge xclk) begin
    if (reset_bit_duration) begin
      state      <= wait_pause;
      pause_seen <= 1'b0;
      start      <= 1'b0;
      ts_stb     <= 1'b0;
      ser_do_stb <= 1'b0;
      frame_err  <= 1'b0;
    end else begin
      start      <= wstart;
      ts_stb     <= wstart && pause_seen;
      ser_do_stb <= shift_bit;
      frame_err  <= (state == receiving) && frame_end && !ser_filt_di;

      if (start) begin
        pause_seen <= 1'b0;
      end else if ((state != receiving) && frame_end && ser_filt_di) begin
        pause_seen <= 1'b1;
      end

      case (state)
        wait_pause: if (frame_end && ser_filt_di) state <= wait_start;
        wait_start: if (start) state <= receiving;
        receiving:  if (frame_end) state <= wait_start;
        default:    state <= wait_pause;
      endcase
    end
  end

  always_ff @(posedge xclk) begin
    if (sample_bit) bit_hold <= ser_filt_di;
    if (shift_bit)  ser_do <= bit_hold;   // Least significant bit first.
  end

endmodule

//--- rtl/serial_byte_fifo.sv
`timescale 1ns/1ps
`include "serial_cmd_defines.svh"

module serial_byte_fifo (
  input  logic                   xclk,
  input  logic                   reset_bit_duration,
  input  logic                   ser_do,
  input  logic                   ser_do_stb,
  input  logic                   ts_stb,
  input  logic                   frame_err,
  input  logic                   fifo_pop,
  output logic                   fifo_empty,
  output serial_data_pkg::byte_t head_byte,
  output logic                   head_first,
  output logic                   head_err,
  output logic                   overflow
);
  import serial_data_pkg::*;

  byte_t     shift_byte;
  bit_pos_t  bit_pos;
  logic      first_pend;    // Set from ts_stb until its byte is stored.
  logic      wr_req;
  logic      wr_err;

  byte_t     mem_byte  [`SER_FIFO_DEPTH];
  logic      mem_first [`SER_FIFO_DEPTH];
  logic      mem_err   [`SER_FIFO_DEPTH];
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  fifo_cnt_t count;
  logic      full;
  logic      push;

  // **********************************************************
  // Byte assembly
  // **********************************************************

  always_ff @(posedge xclk) begin
    if (ser_do_stb) shift_byte <= {ser_do, shift_byte[7:1]};
  end

  always_ff @(posedge xclk) begin
    if (reset_bit_duration) begin
      bit_pos    <= '0;
      first_pend <= 1'b0;
      wr_req     <= 1'b0;
      wr_err     <= 1'b0;
    end else begin
      // A bad stop bit closes the byte no matter how many bits arrived.
      wr_req <= (ser_do_stb && (bit_pos == bit_pos_t'(7))) || frame_err;
      wr_err <= frame_err;
      if (frame_err) begin
        bit_pos <= '0;
      end else if (ser_do_stb) begin
        bit_pos <= bit_pos + 1'b1;                 // Wraps to zero after the eighth bit.
      end
      if (ts_stb) first_pend <= 1'b1;
      else if (wr_req) first_pend <= 1'b0;
    end
  end

  // **********************************************************
  // Four-entry circular buffer
  // **********************************************************

  assign full       = (count == fifo_cnt_t'(`SER_FIFO_DEPTH));
  assign push       = wr_req && !full;
  assign fifo_empty = (count == '0);
  assign head_byte  = mem_byte[rd_ptr];
  assign head_first = mem_first[rd_ptr];
  assign head_err   = mem_err[rd_ptr];

  always_ff @(posedge xclk) begin
    if (push) begin
      mem_byte[wr_ptr]  <= shift_byte;
      mem_first[wr_ptr] <= first_pend;
      mem_err[wr_ptr]   <= wr_err;
    end
  end

  always_ff @(posedge xclk) begin
    if (reset_bit_duration) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push)     wr_ptr <= wr_ptr + 1'b1;
      if (fifo_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, fifo_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (wr_req && full) overflow <= 1'b1;  // Byte is lost, flag stays until reset.
    end
  end

endmodule

//--- rtl/serial_cmd_parser.sv
`timescale 1ns/1ps
`include "serial_cmd_defines.svh"

module serial_cmd_parser (
  input  logic                       xclk,
  input  logic                       reset_bit_duration,
  input  logic                       fifo_empty,
  input  serial_data_pkg::byte_t     head_byte,
  input  logic                       head_first,
  input  logic                       head_err,
  output logic                       fifo_pop,
  output logic                       wr_stb,
  output serial_data_pkg::reg_addr_t wr_addr,
  output serial_data_pkg::reg_data_t wr_data,
  output serial_data_pkg::drop_cnt_t drop_count
);
  import serial_data_pkg::*;

  parse_state_t state;
  pkt_idx_t     byte_idx;
  logic         pkt_bad;      // Some byte of this packet had a stop-bit error.
  byte_t        data_lo;
  logic         last_byte;
  logic         good_pkt;
  logic         drop;

  assign fifo_pop  = (state == pop);
  assign last_byte = (byte_idx == pkt_idx_t'(`SER_PKT_BYTES - 1));

  // **********************************************************
  // Packet decisions on the popped byte
  // **********************************************************

  assign good_pkt = fifo_pop && !head_first && last_byte && !pkt_bad && !head_err;

  // A new packet start cuts off an unfinished one. A stray byte with no
  // packet open is thrown away.
  assign drop = fifo_pop &&
                ((head_first && (byte_idx != '0)) ||
                 (!head_first && (byte_idx == '0)) ||
                 (!head_first && last_byte && (pkt_bad || head_err)));

  always_ff @(posedge xclk) begin
    if (reset_bit_duration) begin
      state      <= idle;
      byte_idx   <= '0;
      pkt_bad    <= 1'b0;
      wr_stb     <= 1'b0;
      drop_count <= '0;
    end else begin
      wr_stb <= good_pkt;
      if (drop && (drop_count != '1)) drop_count <= drop_count + 1'b1;

      case (state)
        idle:    if (!fifo_empty) state <= pop;
        pop:     state <= take;
        take:    state <= idle;      // Lets the FIFO count settle.
        default: state <= idle;
      endcase

      if (fifo_pop) begin
        if (head_first) begin
          byte_idx <= pkt_idx_t'(1);
          pkt_bad  <= head_err;
        end else if (byte_idx != '0) begin
          if (last_byte) begin
            byte_idx <= '0;
          end else begin
            byte_idx <= byte_idx + 1'b1;
            pkt_bad  <= pkt_bad | head_err;
          end
        end
      end
    end
  end

  // Address and data words.
  always_ff @(posedge xclk) begin
    if (fifo_pop && head_first) wr_addr <= head_byte;
    if (fifo_pop && !head_first && (byte_idx != '0) && !last_byte) data_lo <= head_byte;
    if (good_pkt) wr_data <= {head_byte, data_lo};   // High byte arrives last.
  end

endmodule

//--- rtl/serial_cmd_top.sv
`timescale 1ns/1ps

module serial_cmd_top (
  input  logic                          xclk,
  input  logic                          reset_bit_duration,
  input  serial_line_pkg::half_period_t bit_half_period,
  input  logic                          ser_di,
  output logic                          wr_stb,
  output serial_data_pkg::reg_addr_t    wr_addr,
  output serial_data_pkg::reg_data_t    wr_data,
  output serial_data_pkg::drop_cnt_t    drop_count,
  output logic                          overflow
);
  import serial_data_pkg::*;

  logic  ser_do;
  logic  ser_do_stb;
  logic  ts_stb;
  logic  frame_err;
  logic  fifo_empty;
  logic  fifo_pop;
  byte_t head_byte;
  logic  head_first;
  logic  head_err;

  // Line side. Bits, first-byte marks and stop errors.
  rs232_rcv u_rcv (
    .xclk               (xclk),
    .reset_bit_duration (reset_bit_duration),
    .bit_half_period    (bit_half_period),
    .ser_di             (ser_di),
    .ser_do             (ser_do),
    .ser_do_stb         (ser_do_stb),
    .ts_stb             (ts_stb),
    .frame_err          (frame_err)
  );

  serial_byte_fifo u_fifo (
    .xclk               (xclk),
    .reset_bit_duration (reset_bit_duration),
    .ser_do             (ser_do),
    .ser_do_stb         (ser_do_stb),
    .ts_stb             (ts_stb),
    .frame_err          (frame_err),
    .fifo_pop           (fifo_pop),
    .fifo_empty         (fifo_empty),
    .head_byte          (head_byte),
    .head_first         (head_first),
    .head_err           (head_err),
    .overflow           (overflow)
  );

  serial_cmd_parser u_parser (
    .xclk               (xclk),
    .reset_bit_duration (reset_bit_duration),
    .fifo_empty         (fifo_empty),
    .head_byte          (head_byte),
    .head_first         (head_first),
    .head_err           (head_err),
    .fifo_pop           (fifo_pop),
    .wr_stb             (wr_stb),
    .wr_addr            (wr_addr),
    .wr_data            (wr_data),
    .drop_count         (drop_count)
  );

endmodule

//--- tb/serial_cmd_tb.sv
`timescale 1ns/1ps

module serial_cmd_tb;
  import serial_line_pkg::*;
  import serial_data_pkg::*;

  localparam int N_ROWS     = 12;
  localparam int HALF       = 4;
  localparam int BIT_CYC    = 2 * HALF;
  localparam int PAUSE_BITS = 12;
  localparam int NO_BAD     = -1;

  logic         xclk;
  logic         reset_bit_duration;
  half_period_t bit_half_period;
  logic         ser_di;
  logic         wr_stb;
  reg_addr_t    wr_addr;
  reg_data_t    wr_data;
  drop_cnt_t    drop_count;
  logic         overflow;

  // **********************************************************
  // Stimulus table with one row per packet
  // **********************************************************

  string     row_name   [N_ROWS];
  bit        row_pause  [N_ROWS];
  int        row_nbytes [N_ROWS];
  int        row_bad    [N_ROWS];   // Byte sent with a low stop bit.
  reg_addr_t row_addr   [N_ROWS];
  reg_data_t row_data   [N_ROWS];
  bit        row_write  [N_ROWS];   // Set for a write, clear for a drop.

  logic [31:0] lcg_state;
  reg_addr_t   seen_addr [$];
  reg_data_t   seen_data [$];
  int          mismatches;
  int          failures;
  int          cycle_count;
  int          cycle_limit;
  int          exp_writes;
  int          exp_drops;

  serial_cmd_top UUT (
    .xclk               (xclk),
    .reset_bit_duration (reset_bit_duration),
    .bit_half_period    (bit_half_period),
    .ser_di             (ser_di),
    .wr_stb             (wr_stb),
    .wr_addr            (wr_addr),
    .wr_data            (wr_data),
    .drop_count         (drop_count),
    .overflow           (overflow)
  );

  initial xclk = 1'b0;
  always #4 xclk = ~xclk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic add_row(input int r, input string name, input bit pause, input int nbytes,
                         input int bad, input bit write);
    row_name[r]   = name;
    row_pause[r]  = pause;
    row_nbytes[r] = nbytes;
    row_bad[r]    = bad;
    row_write[r]  = write;
    lcg_state     = lcg_next(lcg_state);
    row_addr[r]   = lcg_state[31:24];
    lcg_state     = lcg_next(lcg_state);
    row_data[r]   = lcg_state[31:16];
  endtask

  // Address first, then the data word low byte first.
  function automatic byte_t frame_byte(input int r, input int k);
    if (k == 0) return row_addr[r];
    if (k == 1) return byte_t'(row_data[r] % 256);
    return byte_t'(row_data[r] / 256);
  endfunction

  // **********************************************************
  // Line driver that changes the line on falling edges
  // **********************************************************

  task automatic drive_bit(input logic v);
    ser_di = v;
    repeat (BIT_CYC) @(negedge xclk);
  endtask

  task automatic send_idle(input int nbits);
    repeat (nbits) drive_bit(1'b1);
  endtask

  task automatic send_frame(input byte_t b, input bit stop_ok);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) drive_bit(b[i]);
    drive_bit(stop_ok);
    if (!stop_ok) drive_bit(1'b1);   // Gives the next start bit a falling edge.
  endtask

  // **********************************************************
  // Monitor, timeout and checks
  // **********************************************************

  always @(negedge xclk) begin
    if (!reset_bit_duration && wr_stb) begin
      seen_addr.push_back(wr_addr);
      seen_data.push_back(wr_data);
    end
  end

  always @(posedge xclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: %0d of %0d writes seen, drop count %0d of %0d after %0d cycles",
               seen_addr.size(), exp_writes, drop_count, exp_drops, cycle_count);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic check_write(input string name, input reg_addr_t exp_addr,
                             input reg_data_t exp_data, input reg_addr_t act_addr,
                             input reg_data_t act_data);
    if ((act_addr !== exp_addr) || (act_data !== exp_data)) begin
      mismatches++;
      $display("mismatch %s: expected addr %02h data %04h, actual addr %02h data %04h",
               name, exp_addr, exp_data, act_addr, act_data);
    end
  endtask

  task automatic check_drops(input string name, input drop_cnt_t exp, input drop_cnt_t act);
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatches++;
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  initial begin
    int r;
    int k;
    int w;
    reset_bit_duration = 1'b1;
    bit_half_period    = half_period_t'(HALF);
    ser_di             = 1'b1;
    lcg_state          = 32'h7aea8fb3;
    mismatches         = 0;
    failures           = 0;
    cycle_count        = 0;

    add_row(0,  "first_write",    1, 3, NO_BAD, 1);
    add_row(1,  "second_write",   1, 3, NO_BAD, 1);
    add_row(2,  "bad_stop_mid",   1, 3, 1,      0);
    add_row(3,  "write_after_bad", 1, 3, NO_BAD, 1);
    add_row(4,  "cut_packet",     1, 2, NO_BAD, 0);
    add_row(5,  "write_after_cut", 1, 3, NO_BAD, 1);
    add_row(6,  "stray_pair",     0, 2, NO_BAD, 0);
    add_row(7,  "bad_stop_addr",  1, 3, 0,      0);
    add_row(8,  "bad_stop_high",  1, 3, 2,      0);
    add_row(9,  "write_again",    1, 3, NO_BAD, 1);
    add_row(10, "stray_single",   0, 1, NO_BAD, 0);
    add_row(11, "last_write",     1, 3, NO_BAD, 1);

    exp_writes  = 0;
    exp_drops   = 0;
    cycle_limit = PAUSE_BITS * BIT_CYC + 200;   // Closing idle time plus margin.
    for (r = 0; r < N_ROWS; r++) begin
      cycle_limit += (row_nbytes[r] * 10 + (row_pause[r] ? PAUSE_BITS : 0)) * BIT_CYC;
      if (row_write[r]) exp_writes++;
      else exp_drops += row_pause[r] ? 1 : row_nbytes[r];   // Stray bytes drop one by one.
    end

    repeat (2) @(posedge xclk);
    @(negedge xclk);
    reset_bit_duration = 1'b0;

    for (r = 0; r < N_ROWS; r++) begin
      if (row_pause[r]) send_idle(PAUSE_BITS);
      for (k = 0; k < row_nbytes[r]; k++) send_frame(frame_byte(r, k), k != row_bad[r]);
    end
    send_idle(PAUSE_BITS);

    while ((seen_addr.size() < exp_writes) || (drop_count < drop_cnt_t'(exp_drops))) begin
      @(negedge xclk);
    end

    w = 0;
    for (r = 0; r < N_ROWS; r++) begin
      if (row_write[r]) begin
        check_write(row_name[r], row_addr[r], row_data[r], seen_addr[w], seen_data[w]);
        w++;
      end
    end
    if (seen_addr.size() > exp_writes) begin
      failures++;
      $display("DUT issued %0d writes where %0d were due", seen_addr.size(), exp_writes);
    end
    check_drops("drop_count", drop_cnt_t'(exp_drops), drop_count);
    check_flag("overflow", 1'b0, overflow);

    $display("Result: %0d value mismatches, %0d other errors", mismatches, failures);
    if ((mismatches == 0) && (failures == 0)) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- serial_cmd.f
+incdir+rtl
rtl/serial_line_pkg.sv
rtl/serial_data_pkg.sv
rtl/rs232_rcv.sv
rtl/serial_byte_fifo.sv
rtl/serial_cmd_parser.sv
rtl/serial_cmd_top.sv
tb/serial_cmd_tb.sv

//--- Bender.yml
package:
  name: serial_cmd

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/serial_line_pkg.sv
      - rtl/serial_data_pkg.sv
      - rtl/rs232_rcv.sv
      - rtl/serial_byte_fifo.sv
      - rtl/serial_cmd_parser.sv
      - rtl/serial_cmd_top.sv

  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/serial_cmd_tb.sv
